/* vlog.f */
ntm_math_pkg.sv
ntm_ctrl_pkg.sv
ntm_scalar_exponentiator.sv
ntm_scalar_reciprocal.sv
ntm_scalar_logistic_function.sv
dnc_write_gate.sv
dnc_write_gate_tb.sv

/* Makefile */
SRCS := $(shell cat vlog.f)

.PHONY: all run clean

all: run

obj_dir/Vdnc_write_gate_tb: vlog.f $(SRCS)
	verilator --binary --top-module dnc_write_gate_tb -f vlog.f -o Vdnc_write_gate_tb

run: obj_dir/Vdnc_write_gate_tb
	./obj_dir/Vdnc_write_gate_tb

clean:
	rm -rf obj_dir

/* dnc_write_gate_tb.sv */
// DATA_SIZE fixed at 32; random gw_in spans +/- 16.0 and the run stops at the first error
module dnc_write_gate_tb
  import ntm_math_pkg::*;
;

  //////////////////////////////////////////////////
  // Test setup
  //////////////////////////////////////////////////

  localparam int DATA_SIZE    = 32;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_FIXED    = 14;
  localparam int NUM_RAND     = 24;
  localparam int NUM_TESTS    = NUM_FIXED + NUM_RAND;
  // Random gw_in width, sign included
  localparam int RAND_BITS    = 21;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (DATA_SIZE + 10) + RESET_CYCLES;

  // One table row
  typedef struct packed {
    logic signed [DATA_SIZE-1:0] gw_in;
    logic        [DATA_SIZE-1:0] gw_out;
  } gate_vec_t;

  logic                        clk;
  logic                        rst;
  logic                        start;
  logic                        ready;
  logic signed [DATA_SIZE-1:0] gw_in;
  logic        [DATA_SIZE-1:0] gw_out;

  gate_vec_t   vec_tab[$];
  logic [15:0] lfsr_state = 16'd56;
  int          starts_seen = 0;
  int          readies_seen = 0;
  bit          in_reset = 1'b0;

  dnc_write_gate #(
    .DATA_SIZE(DATA_SIZE)
  ) dut_i (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .ready (ready),
    .gw_in (gw_in),
    .gw_out(gw_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Reference model and stimulus helpers
  //////////////////////////////////////////////////

  // sigmoid(x) = 2^32 / (1.0 + exp2(-x * log2(e))), linear mantissa
  function automatic logic [DATA_SIZE-1:0] model_gate(input logic signed [DATA_SIZE-1:0] x);
    longint neg_x;
    longint p;
    longint k;
    longint f;
    longint mant;
    longint e;
    neg_x = -longint'(x);
    p     = (neg_x * longint'(LOG2E_Q)) >>> FRACT_SIZE;
    k     = p >>> FRACT_SIZE;
    f     = p & longint'(ONE_Q - 1);
    mant  = longint'(ONE_Q) + f;
    // Exponent too big, sigmoid collapses to zero
    if (k >= longint'(DATA_SIZE - 18)) begin
      return '0;
    end
    if (k < longint'(-FRACT_SIZE)) begin
      e = 0;
    end else if (k < 0) begin
      e = mant >> (-k);
    end else begin
      e = mant << k;
    end
    return DATA_SIZE'((longint'(1) << (2 * FRACT_SIZE)) / (longint'(ONE_Q) + e));
  endfunction

  // Taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic draw_gate_in(output logic signed [DATA_SIZE-1:0] x);
    logic [RAND_BITS-1:0] bits;
    bits = '0;
    for (int i = 0; i < RAND_BITS; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      bits       = {bits[RAND_BITS-2:0], lfsr_state[0]};
    end
    x = {{(DATA_SIZE - RAND_BITS){bits[RAND_BITS-1]}}, bits};
  endtask

  task automatic add_entry(input logic signed [DATA_SIZE-1:0] x,
                           input logic        [DATA_SIZE-1:0] y);
    gate_vec_t v;
    v.gw_in  = x;
    v.gw_out = y;
    vec_tab.push_back(v);
  endtask

  task automatic add_model_entry(input logic signed [DATA_SIZE-1:0] x);
    add_entry(x, model_gate(x));
  endtask

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_gate(input logic [DATA_SIZE-1:0] got,
                            input logic [DATA_SIZE-1:0] exp,
                            input int                   idx);
    if (got !== exp) begin
      fail_run($sformatf("mismatch gw_out entry %0d got 0x%08h expected 0x%08h",
                         idx, got, exp));
    end
  endtask

  task automatic check_ready(input int n_ready, input int n_start);
    if (n_ready != n_start) begin
      fail_run($sformatf("ready pulsed %0d times for %0d start pulses", n_ready, n_start));
    end
  endtask

  // Counts start and ready as the DUT sees them on each edge
  always @(posedge clk) begin
    if (rst) begin
      // First edge still sees the power-up value
      if (in_reset && ready !== 1'b0) begin
        fail_run("ready was not low during reset");
      end
      in_reset = 1'b1;
    end else begin
      if (start === 1'b1) begin
        starts_seen++;
      end
      if (ready === 1'b1) begin
        readies_seen++;
        check_ready(readies_seen, starts_seen);
      end else if (ready !== 1'b0) begin
        fail_run("ready was unknown after reset");
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_run("watchdog expired before all gate entries finished");
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    gate_vec_t vec;
    int        waited;
    logic signed [DATA_SIZE-1:0] rnd;
    rst   = 1'b1;
    start = 1'b0;
    gw_in = '0;

    // Known corners with literal results
    add_entry('0, DATA_SIZE'(32'h8000));
    add_entry(DATA_SIZE'(20 * ONE_Q), DATA_SIZE'(ONE_Q));
    add_entry(DATA_SIZE'(8192 * ONE_Q), DATA_SIZE'(ONE_Q));
    add_entry(DATA_SIZE'(-20 * ONE_Q), '0);
    add_entry(DATA_SIZE'(-8192 * ONE_Q), '0);
    // Mid range and the edges of both flags
    add_model_entry(DATA_SIZE'(ONE_Q));
    add_model_entry(DATA_SIZE'(-ONE_Q));
    add_model_entry(DATA_SIZE'(ONE_Q / 2));
    add_model_entry(DATA_SIZE'(-ONE_Q / 4));
    add_model_entry(DATA_SIZE'(3 * ONE_Q));
    add_model_entry(DATA_SIZE'(-3 * ONE_Q));
    add_model_entry(DATA_SIZE'(-9 * ONE_Q));
    add_model_entry(DATA_SIZE'(-10 * ONE_Q));
    add_model_entry(DATA_SIZE'(11 * ONE_Q));
    for (int i = 0; i < NUM_RAND; i++) begin
      draw_gate_in(rnd);
      add_model_entry(rnd);
    end
    if (vec_tab.size() != NUM_TESTS) begin
      fail_run("stimulus table length does not match the test count");
    end

    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    foreach (vec_tab[i]) begin
      vec = vec_tab[i];
      @(posedge clk);
      start <= 1'b1;
      gw_in <= vec.gw_in;
      @(posedge clk);
      start <= 1'b0;
      // Previous result still held on the edge that takes start
      if (i > 0) begin
        check_gate(gw_out, vec_tab[i-1].gw_out, i - 1);
      end
      // Latency depends on the saturate path
      waited = 0;
      while (ready !== 1'b1) begin
        @(posedge clk);
        waited++;
        if (waited > DATA_SIZE + 10) begin
          fail_run($sformatf("no ready within %0d cycles for entry %0d", waited, i));
        end
      end
      check_gate(gw_out, vec.gw_out, i);
      // Result must hold after the strobe
      @(posedge clk);
      check_gate(gw_out, vec.gw_out, i);
    end

    repeat (4) @(posedge clk);
    check_gate(gw_out, vec.gw_out, NUM_TESTS - 1);
    check_ready(readies_seen, starts_seen);
    $display("sim passed");
    $finish;
  end

endmodule

/* dnc_write_gate.sv */
// gw_in must stay inside +/- 2^(DATA_SIZE-18); a start while busy is ignored
module dnc_write_gate #(
  parameter int DATA_SIZE = 32
) (
  input  logic                        clk,
  input  logic                        rst,

  // Control
  input  logic                        start,
  output logic                        ready,

  // Data
  input  logic signed [DATA_SIZE-1:0] gw_in,
  output logic        [DATA_SIZE-1:0] gw_out
);

  //////////////////////////////////////////////////
  // Write gate gw = sigmoid(raw gw)
  //////////////////////////////////////////////////

  // Timing is that of the sigmoid unit
  ntm_scalar_logistic_function #(
    .DATA_SIZE(DATA_SIZE)
  ) ntm_scalar_logistic_function_i (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .ready   (ready),
    .data_in (gw_in),
    .data_out(gw_out)
  );

endmodule

/* ntm_scalar_logistic_function.sv */
// sigmoid(x) = 1 / (1 + exp(-x)) in Q.16; latency varies, so wait for ready
module ntm_scalar_logistic_function
  import ntm_math_pkg::*;
  import ntm_ctrl_pkg::*;
#(
  parameter int DATA_SIZE = 32
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        start,
  output logic                        ready,
  input  logic signed [DATA_SIZE-1:0] data_in,
  output logic        [DATA_SIZE-1:0] data_out
);

  logistic_state_e             state;
  logic signed [DATA_SIZE-1:0] neg_in;

  // Exponentiator side
  logic                 exp_start;
  logic                 exp_ready;
  logic [DATA_SIZE-1:0] exp_data;
  exp_flags_t           exp_flags;

  // Reciprocal side
  logic                 rcp_start;
  logic                 rcp_ready;
  logic [DATA_SIZE-1:0] rcp_den;
  logic [DATA_SIZE-1:0] rcp_quot;

  // exp_data holds until the next exponent start
  assign rcp_den = exp_data + DATA_SIZE'(ONE_Q);

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= LGS_IDLE;
      ready     <= 1'b0;
      exp_start <= 1'b0;
      rcp_start <= 1'b0;
    end else begin
      ready     <= 1'b0;
      exp_start <= 1'b0;
      rcp_start <= 1'b0;
      case (state)
        LGS_IDLE: begin
          if (start) begin
            exp_start <= 1'b1;
            state     <= LGS_EXP;
          end
        end
        LGS_EXP: begin
          if (exp_ready) begin
            // Huge exp(-x) means sigmoid is 0, skip the divider
            if (exp_flags.saturated) begin
              ready <= 1'b1;
              state <= LGS_DONE;
            end else begin
              rcp_start <= 1'b1;
              state     <= LGS_RECIP;
            end
          end
        end
        LGS_RECIP: begin
          if (rcp_ready) begin
            ready <= 1'b1;
            state <= LGS_DONE;
          end
        end
        LGS_DONE: begin
          state <= LGS_IDLE;
        end
        default: begin
          state <= LGS_IDLE;
        end
      endcase
    end
  end

  // Operand and result registers
  always_ff @(posedge clk) begin
    if (state == LGS_IDLE && start) begin
      neg_in <= -data_in;
    end
    if (state == LGS_EXP && exp_ready && exp_flags.saturated) begin
      data_out <= '0;
    end
    if (state == LGS_RECIP && rcp_ready) begin
      data_out <= rcp_quot;
    end
  end

  //////////////////////////////////////////////////
  // Arithmetic units
  //////////////////////////////////////////////////

  ntm_scalar_exponentiator #(
    .DATA_SIZE(DATA_SIZE)
  ) ntm_scalar_exponentiator_i (
    .clk     (clk),
    .rst     (rst),
    .start   (exp_start),
    .data_in (neg_in),
    .ready   (exp_ready),
    .data_out(exp_data),
    .flags   (exp_flags)
  );

  ntm_scalar_reciprocal #(
    .DATA_SIZE(DATA_SIZE)
  ) ntm_scalar_reciprocal_i (
    .clk        (clk),
    .rst        (rst),
    .start      (rcp_start),
    .denominator(rcp_den),
    .ready      (rcp_ready),
    .quotient   (rcp_quot)
  );

  // Result strobe only from the final state
  assert property (@(posedge clk) disable iff (rst)
    ready |-> state == LGS_DONE);

endmodule

/* ntm_scalar_reciprocal.sv */
// Computes floor(2^32 / denominator); denominator must be at least 1.0 and start only when idle
module ntm_scalar_reciprocal
  import ntm_math_pkg::*;
  import ntm_ctrl_pkg::*;
#(
  parameter int DATA_SIZE = 32
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic [DATA_SIZE-1:0] denominator,
  output logic                 ready,
  output logic [DATA_SIZE-1:0] quotient
);

  localparam int CNT_W = $clog2(DATA_SIZE);

  // 1.0 in Q.32 as a double-width dividend
  localparam logic [2*DATA_SIZE-1:0] DIVIDEND = (2*DATA_SIZE)'(1) << (2*FRACT_SIZE);

  recip_state_e         state;
  logic [CNT_W-1:0]     cnt;
  logic [DATA_SIZE-1:0] den_q;
  // Partial remainder, always below den_q
  logic [DATA_SIZE-1:0] rem_q;
  // Dividend bits shift out the top, quotient bits shift in the bottom
  logic [DATA_SIZE-1:0] acc_q;
  logic [DATA_SIZE:0]   trial;
  logic [DATA_SIZE:0]   diff;
  logic                 q_bit;

  //////////////////////////////////////////////////
  // Restoring step
  //////////////////////////////////////////////////

  assign trial = {rem_q, acc_q[DATA_SIZE-1]};
  assign diff  = trial - {1'b0, den_q};
  // No borrow means the subtraction is kept
  assign q_bit = ~diff[DATA_SIZE];

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= RCP_IDLE;
      ready <= 1'b0;
      cnt   <= '0;
    end else begin
      ready <= 1'b0;
      case (state)
        RCP_IDLE: begin
          if (start) begin
            state <= RCP_SHIFT;
            cnt   <= CNT_W'(DATA_SIZE - 1);
          end
        end
        RCP_SHIFT: begin
          // One quotient bit per cycle
          if (cnt == '0) begin
            state <= RCP_DONE;
            ready <= 1'b1;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        RCP_DONE: begin
          state <= RCP_IDLE;
        end
        default: begin
          state <= RCP_IDLE;
        end
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (state == RCP_IDLE && start) begin
      den_q <= denominator;
      // Upper dividend part is already below any legal denominator
      rem_q <= DIVIDEND[2*DATA_SIZE-1:DATA_SIZE];
      acc_q <= DIVIDEND[DATA_SIZE-1:0];
    end else if (state == RCP_SHIFT) begin
      rem_q <= q_bit ? diff[DATA_SIZE-1:0] : trial[DATA_SIZE-1:0];
      acc_q <= {acc_q[DATA_SIZE-2:0], q_bit};
      if (cnt == '0) begin
        quotient <= {acc_q[DATA_SIZE-2:0], q_bit};
      end
    end
  end

  // Denominator range keeps the quotient and first remainder in bounds
  assert property (@(posedge clk) disable iff (rst)
    start |-> denominator >= DATA_SIZE'(ONE_Q));

  // Sequencer never restarts a running division
  assert property (@(posedge clk) disable iff (rst)
    start |-> state == RCP_IDLE);

endmodule

/* ntm_scalar_exponentiator.sv */
// Input must stay inside +/- 2^(DATA_SIZE-18); linear mantissa only, no rounding
module ntm_scalar_exponentiator
  import ntm_math_pkg::*;
#(
  parameter int DATA_SIZE = 32
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        start,
  input  logic signed [DATA_SIZE-1:0] data_in,
  output logic                        ready,
  output logic        [DATA_SIZE-1:0] data_out,
  output exp_flags_t                  flags
);

  // Full product, then product >>> 16, then integer part k
  localparam int PROD_W = DATA_SIZE + 18;
  localparam int P_W    = PROD_W - FRACT_SIZE;
  localparam int K_W    = P_W - FRACT_SIZE;
  localparam int SH_W   = $clog2(DATA_SIZE);

  localparam logic signed [PROD_W-1:0] LOG2E_W = PROD_W'(LOG2E_Q);
  // Smallest k whose result no longer fits
  localparam logic signed [K_W-1:0]    SAT_K   = K_W'(DATA_SIZE - 18);
  // Below this k the result is under 2^-16
  localparam logic signed [K_W-1:0]    UNF_K   = K_W'(-FRACT_SIZE);

  logic signed [PROD_W-1:0] prod;
  logic signed [P_W-1:0]    p_q;
  logic                     p_valid;
  logic signed [K_W-1:0]    k;
  logic signed [K_W-1:0]    neg_k;
  logic [FRACT_SIZE-1:0]    f;
  logic [DATA_SIZE-1:0]     mant;
  exp_flags_t               flags_d;

  //////////////////////////////////////////////////
  // Stage 1 product x * log2(e)
  //////////////////////////////////////////////////

  assign prod = PROD_W'(data_in) * LOG2E_W;

  //////////////////////////////////////////////////
  // Stage 2 split into 2^k * (1 + f)
  //////////////////////////////////////////////////

  // Floor of p / 2^16 and its fraction
  assign k     = p_q[P_W-1:FRACT_SIZE];
  assign f     = p_q[FRACT_SIZE-1:0];
  assign neg_k = -k;

  // Mitchell mantissa
  assign mant = DATA_SIZE'(ONE_Q) + DATA_SIZE'(f);

  assign flags_d.saturated = (k >= SAT_K);
  assign flags_d.underflow = (k < UNF_K);

  // Pipeline valid and result strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      p_valid <= 1'b0;
      ready   <= 1'b0;
    end else begin
      p_valid <= start;
      ready   <= p_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      p_q <= prod[PROD_W-1:FRACT_SIZE];
    end
    if (p_valid) begin
      flags <= flags_d;
      if (flags_d.saturated) begin
        // Clamp to full scale
        data_out <= '1;
      end else if (flags_d.underflow) begin
        data_out <= '0;
      end else if (k[K_W-1]) begin
        data_out <= mant >> neg_k[SH_W-1:0];
      end else begin
        data_out <= mant << k[SH_W-1:0];
      end
    end
  end

  // Each result carries at most one range flag
  assert property (@(posedge clk) disable iff (rst)
    ready |-> !(flags.saturated && flags.underflow));

endmodule

/* ntm_ctrl_pkg.sv */
// State encodings for the sequencers; literals carry a prefix since both share one scope
package ntm_ctrl_pkg;

  //////////////////////////////////////////////////
  // Sequencer states
  //////////////////////////////////////////////////

  // Sigmoid sequencer
  typedef enum logic [1:0] {
    LGS_IDLE,
    LGS_EXP,
    LGS_RECIP,
    LGS_DONE
  } logistic_state_e;

  // Restoring divider
  typedef enum logic [1:0] {
    RCP_IDLE,
    RCP_SHIFT,
    RCP_DONE
  } recip_state_e;

endpackage

/* ntm_math_pkg.sv */
// Q.16 fixed point only; fraction width is fixed here and is not a module parameter
package ntm_math_pkg;

  //////////////////////////////////////////////////
  // Fixed-point format
  //////////////////////////////////////////////////

  // Fraction bits of every scalar
  localparam int FRACT_SIZE = 16;

  // 1.0 in the same format
  localparam int ONE_Q = 1 << FRACT_SIZE;

  // log2(e) scaled by 2^16
  localparam int LOG2E_Q = 94548;

  //////////////////////////////////////////////////
  // Exponent result flags
  //////////////////////////////////////////////////

  typedef struct packed {
    // Result too large for DATA_SIZE
    logic saturated;
    // Result below 2^-16 and forced to zero
    logic underflow;
  } exp_flags_t;

endpackage
